// File: csr_unit.f
logic/csr_addr_pkg.sv
logic/csr_state_pkg.sv
logic/csr_commit_buffer.sv
logic/csr_plain_reg.sv
logic/csr_trap_ctrl.sv
logic/csr_counters.sv
logic/csr_read_port.sv
logic/csr_unit.sv
dv/tb_clock_gen.sv
dv/csr_checker.sv
dv/csr_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the CSR unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f csr_unit.f \
  --top-module csr_unit_tb -o csr_unit_sim

out=$(./obj_dir/csr_unit_sim)
echo "$out"

if echo "$out" | grep -q "^Test OK$"; then
  exit 0
fi
exit 1

// File: dv/csr_unit_tb.sv
//******************************
// testbench top with the DUT, random
// stimulus and the closing report
//******************************

`timescale 1ns/1ps

module csr_unit_tb;
  import csr_addr_pkg::*;
  import csr_state_pkg::*;

  localparam csr_data_t MTVEC_RESET   = 64'h0000_0000_8000_0100;
  localparam csr_addr_t ADDR_UNKNOWN  = 12'h7c0;
  localparam int        N_CYCLES      = 4000;
  localparam int        RESET_TIMEOUT = 64;
  localparam int        DRAIN_TIMEOUT = 8;
  localparam int        DRIVE_DELAY   = 1;

  logic                    clk;
  logic                    reset;
  logic                    wr_en;
  csr_write_t              wr_req;
  logic                    commit;
  logic                    flush;
  logic                    rd_en;
  csr_addr_t               rd_addr;
  logic [COMMIT_CNT_W-1:0] total_commit;
  trap_in_t                trap;
  irq_t                    irq;
  csr_data_t               rd_data;
  logic                    atomic_vio;
  logic                    irq_pending;
  csr_data_t               epc;
  csr_data_t               evec;
  logic [31:0]             rng_state;
  int                      error_count;
  int                      check_count;
  int                      timeouts;

  tb_clock_gen #(.CLK_PERIOD(100), .RESET_CYCLES(16)) u_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  csr_unit #(.MTVEC_RESET(MTVEC_RESET)) dut (
    .clk, .reset,
    .wr_en_i        (wr_en),
    .wr_req_i       (wr_req),
    .commit_i       (commit),
    .flush_i        (flush),
    .rd_en_i        (rd_en),
    .rd_addr_i      (rd_addr),
    .total_commit_i (total_commit),
    .trap_i         (trap),
    .irq_i          (irq),
    .rd_data_o      (rd_data),
    .atomic_vio_o   (atomic_vio),
    .irq_pending_o  (irq_pending),
    .epc_o          (epc),
    .evec_o         (evec)
  );

  csr_checker #(.MTVEC_RESET(MTVEC_RESET)) u_checker (
    .clk, .reset,
    .wr_en_i        (wr_en),
    .wr_req_i       (wr_req),
    .commit_i       (commit),
    .flush_i        (flush),
    .rd_en_i        (rd_en),
    .rd_addr_i      (rd_addr),
    .total_commit_i (total_commit),
    .trap_i         (trap),
    .irq_i          (irq),
    .rd_data_i      (rd_data),
    .atomic_vio_i   (atomic_vio),
    .irq_pending_i  (irq_pending),
    .epc_i          (epc),
    .evec_i         (evec),
    .error_count_o  (error_count),
    .check_count_o  (check_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] draw();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // every kept address plus one that decodes to nothing
  function automatic csr_addr_t pick_addr(input logic [31:0] r);
    case (r % 13)
      0:       return ADDR_MSTATUS;
      1:       return ADDR_MIE;
      2:       return ADDR_MTVEC;
      3:       return ADDR_MSCRATCH;
      4:       return ADDR_MEPC;
      5:       return ADDR_MCAUSE;
      6:       return ADDR_MIP;
      7:       return ADDR_SATP;
      8:       return ADDR_MCYCLE;
      9:       return ADDR_MINSTRET;
      10:      return ADDR_CYCLE;
      11:      return ADDR_INSTRET;
      default: return ADDR_UNKNOWN;
    endcase
  endfunction

  task automatic idle_inputs();
    wr_en        = 1'b0;
    wr_req       = '0;
    commit       = 1'b0;
    flush        = 1'b0;
    rd_en        = 1'b0;
    rd_addr      = '0;
    total_commit = '0;
    trap         = '0;
    irq          = '0;
  endtask

  task automatic drive_random();
    logic [31:0] r;
    r                = draw();
    wr_en            = r[0] & r[1];
    commit           = r[2];
    flush            = (r[5:3] == 3'd0);
    rd_en            = r[6] & r[7];
    // exception and mret are exclusive
    trap.exception   = (r[11:8] == 4'd0);
    trap.mret        = (r[11:8] == 4'd1);
    if (r[13:12] == 2'b00) begin
      irq = irq_t'(r[16:14]);
    end
    total_commit     = COMMIT_CNT_W'(r[31:17] % 15'd5);
    wr_req.addr      = pick_addr(draw());
    wr_req.data      = {draw(), draw()};
    rd_addr          = pick_addr(draw());
    trap.pc          = {draw(), draw()};
    trap.cause       = {draw(), draw()};
  endtask

  task automatic wait_reset_release(output bit ok);
    ok = 1'b0;
    for (int n = 0; n < RESET_TIMEOUT && !ok; n++) begin
      @(posedge clk);
      ok = !reset;
    end
    if (!ok) begin
      $display("timeout: reset still asserted after %0d cycles", RESET_TIMEOUT);
    end
  endtask

  // commit with nothing else going on retires the last read checkpoint
  task automatic drain_checkpoint(output bit ok);
    @(posedge clk);
    #DRIVE_DELAY;
    idle_inputs();
    commit = 1'b1;
    ok     = 1'b0;
    for (int n = 0; n < DRAIN_TIMEOUT && !ok; n++) begin
      @(negedge clk);
      ok = !atomic_vio;
    end
    if (!ok) begin
      $display("timeout: atomic violation flag never dropped after commit");
    end
    @(posedge clk);
    #DRIVE_DELAY;
    commit = 1'b0;
  endtask

  initial begin : main
    bit ok;
    timeouts  = 0;
    rng_state = 32'h1efe_8a98;
    idle_inputs();
    wait_reset_release(ok);
    if (!ok) begin
      timeouts++;
    end else begin
      for (int c = 0; c < N_CYCLES; c++) begin
        @(posedge clk);
        #DRIVE_DELAY;
        drive_random();
      end
      drain_checkpoint(ok);
      if (!ok) begin
        timeouts++;
      end
    end
    repeat (2) @(posedge clk);
    $display("checks %0d, mismatches %0d, timeouts %0d", check_count, error_count, timeouts);
    if (timeouts == 0 && error_count == 0 && check_count > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: dv/csr_checker.sv
//******************************
// reference model of the CSR state
// and per-cycle compare of the DUT outputs
//******************************

`timescale 1ns/1ps

module csr_checker #(
  parameter csr_addr_pkg::csr_data_t MTVEC_RESET = '0
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  wr_en_i,
  input  csr_addr_pkg::csr_write_t              wr_req_i,
  input  logic                                  commit_i,
  input  logic                                  flush_i,
  input  logic                                  rd_en_i,
  input  csr_addr_pkg::csr_addr_t               rd_addr_i,
  input  logic [csr_addr_pkg::COMMIT_CNT_W-1:0] total_commit_i,
  input  csr_state_pkg::trap_in_t               trap_i,
  input  csr_state_pkg::irq_t                   irq_i,
  input  csr_addr_pkg::csr_data_t               rd_data_i,
  input  logic                                  atomic_vio_i,
  input  logic                                  irq_pending_i,
  input  csr_addr_pkg::csr_data_t               epc_i,
  input  csr_addr_pkg::csr_data_t               evec_i,
  output int                                    error_count_o,
  output int                                    check_count_o
);
  import csr_addr_pkg::*;
  import csr_state_pkg::*;

  // writable bits as the ISA places them
  localparam csr_data_t MTVEC_MASK   = ~64'h2;
  localparam csr_data_t MIE_MASK     = 64'h888;
  localparam csr_data_t MSTATUS_MASK = 64'h1888;

  int         errors = 0;
  int         checks = 0;
  privilege_t m_priv;
  csr_data_t  m_mstatus;
  csr_data_t  m_mepc;
  csr_data_t  m_mcause;
  csr_data_t  m_mtvec;
  csr_data_t  m_mscratch;
  csr_data_t  m_mie;
  csr_data_t  m_satp;
  csr_data_t  m_mcycle;
  csr_data_t  m_minstret;
  logic       m_pend_valid;
  csr_write_t m_pend;
  logic       m_chk_valid;
  csr_addr_t  m_chk_addr;
  csr_data_t  m_chk_data;

  assign error_count_o = errors;
  assign check_count_o = checks;

  function automatic csr_data_t model_mip();
    csr_data_t v;
    v     = '0;
    v[3]  = irq_i.m_soft;
    v[7]  = irq_i.m_timer;
    v[11] = irq_i.m_ext;
    return v;
  endfunction

  function automatic csr_data_t model_read(input csr_addr_t addr);
    case (addr)
      ADDR_MSTATUS:              return m_mstatus;
      ADDR_MIE:                  return m_mie;
      ADDR_MTVEC:                return m_mtvec;
      ADDR_MSCRATCH:             return m_mscratch;
      ADDR_MEPC:                 return m_mepc;
      ADDR_MCAUSE:               return m_mcause;
      ADDR_MIP:                  return model_mip();
      ADDR_SATP:                 return m_satp;
      ADDR_MCYCLE, ADDR_CYCLE:   return m_mcycle;
      ADDR_MINSTRET, ADDR_INSTRET: return m_minstret;
      default:                   return '0;
    endcase
  endfunction

  task automatic reset_model();
    m_priv       = MACHINE;
    m_mstatus    = '0;
    m_mepc       = '0;
    m_mcause     = '0;
    m_mtvec      = MTVEC_RESET;
    m_mscratch   = '0;
    m_mie        = '0;
    m_satp       = '0;
    m_mcycle     = '0;
    m_minstret   = '0;
    m_pend_valid = 1'b0;
    m_chk_valid  = 1'b0;
  endtask

  // one clock edge, every rule reads the state from before the edge
  task automatic step_model();
    logic       fire;
    csr_data_t  wdata;
    privilege_t old_priv;
    csr_data_t  old_mstatus;
    fire        = commit_i && m_pend_valid;
    wdata       = m_pend.data;
    old_priv    = m_priv;
    old_mstatus = m_mstatus;
    if (rd_en_i) begin
      m_chk_valid = 1'b1;
      m_chk_addr  = rd_addr_i;
      m_chk_data  = model_read(rd_addr_i);
    end else if (commit_i || flush_i) begin
      m_chk_valid = 1'b0;
    end
    m_mcycle   = m_mcycle + 64'd1;
    m_minstret = m_minstret + csr_data_t'(total_commit_i);
    if (fire) begin
      case (m_pend.addr)
        ADDR_MTVEC:    m_mtvec = (wdata & MTVEC_MASK) | (m_mtvec & ~MTVEC_MASK);
        ADDR_MIE:      m_mie = (wdata & MIE_MASK) | (m_mie & ~MIE_MASK);
        ADDR_MSCRATCH: m_mscratch = wdata;
        ADDR_SATP:     m_satp = wdata;
        ADDR_MCYCLE:   m_mcycle = wdata;
        ADDR_MINSTRET: m_minstret = wdata;
        ADDR_MEPC:     m_mepc = wdata & ~64'd1;
        ADDR_MCAUSE:   m_mcause = wdata;
        ADDR_MSTATUS: begin
          if (!trap_i.exception && !trap_i.mret) begin
            m_mstatus = wdata & MSTATUS_MASK;
          end
        end
        default: ;
      endcase
    end
    if (trap_i.exception) begin
      m_mepc           = trap_i.pc & ~64'd1;
      m_mcause         = trap_i.cause;
      m_mstatus[7]     = old_mstatus[3];
      m_mstatus[3]     = 1'b0;
      m_mstatus[12:11] = old_priv;
      m_priv           = MACHINE;
    end else if (trap_i.mret) begin
      m_mstatus[3]     = old_mstatus[7];
      m_mstatus[7]     = 1'b1;
      m_mstatus[12:11] = USER;
      m_priv           = (old_mstatus[12:11] == 2'b11) ? MACHINE : USER;
    end
    if (wr_en_i) begin
      m_pend       = wr_req_i;
      m_pend_valid = 1'b1;
    end else if (commit_i || flush_i) begin
      m_pend_valid = 1'b0;
    end
  endtask

  task automatic compare(input string what, input csr_data_t got, input csr_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      reset_model();
    end else begin
      step_model();
    end
  end

  // outputs have settled half a cycle after the inputs changed
  always @(negedge clk) begin
    csr_data_t exp_vio;
    csr_data_t exp_irq;
    if (!reset) begin
      exp_vio = csr_data_t'(m_chk_valid && (model_read(m_chk_addr) != m_chk_data));
      exp_irq = csr_data_t'((|(m_mie & model_mip())) && (m_priv == USER || m_mstatus[3]));
      compare($sformatf("rd_data_o at %h", rd_addr_i), rd_data_i, model_read(rd_addr_i));
      compare("atomic_vio_o", csr_data_t'(atomic_vio_i), exp_vio);
      compare("irq_pending_o", csr_data_t'(irq_pending_i), exp_irq);
      compare("epc_o", epc_i, m_mepc);
      compare("evec_o", evec_i, m_mtvec);
    end
  end

endmodule

// File: dv/tb_clock_gen.sv
//******************************
// testbench clock and power-on reset
//******************************

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int CLK_PERIOD   = 100,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(CLK_PERIOD / 2) clk_o = ~clk_o;
  end

  // release a little after the edge so no flop races it
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 reset_o = 1'b0;
  end

endmodule

// File: logic/csr_unit.sv
//******************************
// machine-mode CSR unit top level with
// commit buffer, register bank, trap state,
// counters and read port
//******************************

`timescale 1ns/1ps

module csr_unit #(
  parameter csr_addr_pkg::csr_data_t MTVEC_RESET = 64'h0000_0000_8000_0000
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  wr_en_i,
  input  csr_addr_pkg::csr_write_t              wr_req_i,
  input  logic                                  commit_i,
  input  logic                                  flush_i,
  input  logic                                  rd_en_i,
  input  csr_addr_pkg::csr_addr_t               rd_addr_i,
  input  logic [csr_addr_pkg::COMMIT_CNT_W-1:0] total_commit_i,
  input  csr_state_pkg::trap_in_t               trap_i,
  input  csr_state_pkg::irq_t                   irq_i,
  output csr_addr_pkg::csr_data_t               rd_data_o,
  output logic                                  atomic_vio_o,
  output logic                                  irq_pending_o,
  output csr_addr_pkg::csr_data_t               epc_o,
  output csr_addr_pkg::csr_data_t               evec_o
);
  import csr_addr_pkg::*;
  import csr_state_pkg::*;

  localparam csr_data_t MIE_MASK = (csr_data_t'(1) << IRQ_M_SOFT) |
                                   (csr_data_t'(1) << IRQ_M_TIMER) |
                                   (csr_data_t'(1) << IRQ_M_EXT);

  // per-slot reset values and writable bits, mtvec bit 1 stays zero
  localparam csr_data_t SLOT_RESET [N_SLOTS] = '{SLOT_MTVEC: MTVEC_RESET, default: '0};
  localparam csr_data_t SLOT_WR_MASK [N_SLOTS] = '{
    SLOT_MTVEC: ~(csr_data_t'(1) << 1),
    SLOT_MIE:   MIE_MASK,
    default:    '1
  };

  csr_wr_strobe_t wr_strobe;
  csr_data_t      slot_data [N_SLOTS];
  mstatus_t       mstatus;
  csr_data_t      mepc;
  csr_data_t      mcause;
  csr_data_t      mip;
  csr_data_t      mcycle;
  csr_data_t      minstret;

  csr_commit_buffer u_commit_buffer (
    .clk, .reset, .wr_en_i, .wr_req_i, .commit_i, .flush_i,
    .wr_strobe_o (wr_strobe)
  );

  for (genvar i = 0; i < N_SLOTS; i++) begin : g_slot
    csr_plain_reg #(
      .RESET_VAL (SLOT_RESET[i]),
      .WR_MASK   (SLOT_WR_MASK[i])
    ) u_reg (
      .clk, .reset,
      .wr_i      (wr_strobe.slot[i]),
      .wr_data_i (wr_strobe.data),
      .value_o   (slot_data[i])
    );
  end

  csr_trap_ctrl u_trap_ctrl (
    .clk, .reset, .trap_i, .irq_i, .irq_pending_o,
    .wr_strobe_i (wr_strobe),
    .mie_i       (slot_data[SLOT_MIE]),
    .mstatus_o   (mstatus),
    .mepc_o      (mepc),
    .mcause_o    (mcause),
    .mip_o       (mip)
  );

  csr_counters u_counters (
    .clk, .reset, .total_commit_i,
    .wr_strobe_i (wr_strobe),
    .mcycle_o    (mcycle),
    .minstret_o  (minstret)
  );

  csr_read_port u_read_port (
    .clk, .reset, .rd_en_i, .rd_addr_i, .commit_i, .flush_i,
    .slot_data_i (slot_data),
    .mstatus_i   (mstatus),
    .mepc_i      (mepc),
    .mcause_i    (mcause),
    .mip_i       (mip),
    .mcycle_i    (mcycle),
    .minstret_i  (minstret),
    .rd_data_o, .atomic_vio_o
  );

  // trap return target and trap vector
  assign epc_o  = mepc;
  assign evec_o = slot_data[SLOT_MTVEC];

endmodule

// File: logic/csr_read_port.sv
//******************************
// CSR read multiplexer, read checkpoint
// and atomic-read violation flag
//******************************

`timescale 1ns/1ps

module csr_read_port (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    rd_en_i,
  input  csr_addr_pkg::csr_addr_t rd_addr_i,
  input  logic                    commit_i,
  input  logic                    flush_i,
  input  csr_addr_pkg::csr_data_t slot_data_i [csr_addr_pkg::N_SLOTS],
  input  csr_state_pkg::mstatus_t mstatus_i,
  input  csr_addr_pkg::csr_data_t mepc_i,
  input  csr_addr_pkg::csr_data_t mcause_i,
  input  csr_addr_pkg::csr_data_t mip_i,
  input  csr_addr_pkg::csr_data_t mcycle_i,
  input  csr_addr_pkg::csr_data_t minstret_i,
  output csr_addr_pkg::csr_data_t rd_data_o,
  output logic                    atomic_vio_o
);
  import csr_addr_pkg::*;

  logic      chk_valid_q;
  csr_addr_t chk_addr_q;
  csr_data_t chk_data_q;
  csr_data_t chk_now;

  // unknown addresses read as zero
  function automatic csr_data_t read_mux(input csr_addr_t addr);
    csr_data_t val;
    val = '0;
    case (addr)
      ADDR_MSTATUS:              val = mstatus_i;
      ADDR_MEPC:                 val = mepc_i;
      ADDR_MCAUSE:               val = mcause_i;
      ADDR_MIP:                  val = mip_i;
      ADDR_MCYCLE, ADDR_CYCLE:   val = mcycle_i;
      ADDR_MINSTRET, ADDR_INSTRET: val = minstret_i;
      default: begin
        for (int s = 0; s < N_SLOTS; s++) begin
          if (addr == SLOT_ADDR[s]) begin
            val = slot_data_i[s];
          end
        end
      end
    endcase
    return val;
  endfunction

  // same mux serves the live read and the checkpoint compare
  always_comb begin
    rd_data_o = read_mux(rd_addr_i);
    chk_now   = read_mux(chk_addr_q);
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      chk_valid_q <= 1'b0;
    end else if (rd_en_i) begin
      chk_valid_q <= 1'b1;
    end else if (commit_i || flush_i) begin
      chk_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      chk_addr_q <= rd_addr_i;
      chk_data_q <= rd_data_o;
    end
  end

  assign atomic_vio_o = chk_valid_q && (chk_now != chk_data_q);

  // a commit or flush without a new read retires the checkpoint
  a_vio_retired: assert property (@(posedge clk) disable iff (reset)
    (commit_i || flush_i) && !rd_en_i |=> !atomic_vio_o);

endmodule

// File: logic/csr_counters.sv
//******************************
// mcycle and minstret counters
// with committed-write override
//******************************

`timescale 1ns/1ps

module csr_counters (
  input  logic                                  clk,
  input  logic                                  reset,
  input  csr_addr_pkg::csr_wr_strobe_t          wr_strobe_i,
  input  logic [csr_addr_pkg::COMMIT_CNT_W-1:0] total_commit_i,
  output csr_addr_pkg::csr_data_t               mcycle_o,
  output csr_addr_pkg::csr_data_t               minstret_o
);
  import csr_addr_pkg::*;

  csr_data_t mcycle_q;
  csr_data_t minstret_q;
  csr_data_t commit_inc;

  assign commit_inc = {{(CSR_W-COMMIT_CNT_W){1'b0}}, total_commit_i};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
    end else begin
      mcycle_q   <= wr_strobe_i.mcycle   ? wr_strobe_i.data : mcycle_q + 1'b1;
      minstret_q <= wr_strobe_i.minstret ? wr_strobe_i.data : minstret_q + commit_inc;
    end
  end

  assign mcycle_o   = mcycle_q;
  assign minstret_o = minstret_q;

endmodule

// File: logic/csr_trap_ctrl.sv
//******************************
// privilege, mstatus, mepc and mcause,
// trap entry, mret and interrupt pending
//******************************

`timescale 1ns/1ps

module csr_trap_ctrl (
  input  logic                         clk,
  input  logic                         reset,
  input  csr_addr_pkg::csr_wr_strobe_t wr_strobe_i,
  input  csr_state_pkg::trap_in_t      trap_i,
  input  csr_state_pkg::irq_t          irq_i,
  input  csr_addr_pkg::csr_data_t      mie_i,
  output csr_state_pkg::mstatus_t      mstatus_o,
  output csr_addr_pkg::csr_data_t      mepc_o,
  output csr_addr_pkg::csr_data_t      mcause_o,
  output csr_addr_pkg::csr_data_t      mip_o,
  output logic                         irq_pending_o
);
  import csr_addr_pkg::*;
  import csr_state_pkg::*;

  privilege_t priv_q;
  mstatus_t   mstatus_q;
  csr_data_t  mepc_q;
  csr_data_t  mcause_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      priv_q    <= MACHINE;
      mstatus_q <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (trap_i.exception) begin
      // trap entry overrides any committed write this cycle
      mepc_q         <= {trap_i.pc[CSR_W-1:1], 1'b0};
      mcause_q       <= trap_i.cause;
      mstatus_q.mpie <= mstatus_q.mie;
      mstatus_q.mie  <= 1'b0;
      mstatus_q.mpp  <= priv_q;
      priv_q         <= MACHINE;
    end else begin
      if (wr_strobe_i.mepc) begin
        mepc_q <= {wr_strobe_i.data[CSR_W-1:1], 1'b0};
      end
      if (wr_strobe_i.mcause) begin
        mcause_q <= wr_strobe_i.data;
      end
      if (trap_i.mret) begin
        // return to the saved mode, mpp drops back to user
        mstatus_q.mie  <= mstatus_q.mpie;
        mstatus_q.mpie <= 1'b1;
        mstatus_q.mpp  <= USER;
        priv_q         <= (mstatus_q.mpp == MACHINE) ? MACHINE : USER;
      end else if (wr_strobe_i.mstatus) begin
        mstatus_q <= mstatus_t'(wr_strobe_i.data & MSTATUS_WR_MASK);
      end
    end
  end

  // mip mirrors the interrupt lines
  always_comb begin
    mip_o              = '0;
    mip_o[IRQ_M_SOFT]  = irq_i.m_soft;
    mip_o[IRQ_M_TIMER] = irq_i.m_timer;
    mip_o[IRQ_M_EXT]   = irq_i.m_ext;
  end

  // user mode always takes enabled machine interrupts
  assign irq_pending_o = (|(mie_i & mip_o)) && ((priv_q == USER) || mstatus_q.mie);

  assign mstatus_o = mstatus_q;
  assign mepc_o    = mepc_q;
  assign mcause_o  = mcause_q;

  a_trap_xor_mret: assert property (@(posedge clk) disable iff (reset)
    !(trap_i.exception && trap_i.mret));

endmodule

// File: logic/csr_plain_reg.sv
//******************************
// single software-writable CSR with
// reset value and writable-bit mask
//******************************

`timescale 1ns/1ps

module csr_plain_reg #(
  parameter csr_addr_pkg::csr_data_t RESET_VAL = '0,
  parameter csr_addr_pkg::csr_data_t WR_MASK   = '1
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    wr_i,
  input  csr_addr_pkg::csr_data_t wr_data_i,
  output csr_addr_pkg::csr_data_t value_o
);
  import csr_addr_pkg::*;

  csr_data_t value_q;

  // bits outside the mask keep their current value
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      value_q <= RESET_VAL;
    end else if (wr_i) begin
      value_q <= (wr_data_i & WR_MASK) | (value_q & ~WR_MASK);
    end
  end

  assign value_o = value_q;

endmodule

// File: logic/csr_commit_buffer.sv
//******************************
// pending CSR write held until commit,
// decoded into per-register write strobes
//******************************

`timescale 1ns/1ps

module csr_commit_buffer (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        wr_en_i,
  input  csr_addr_pkg::csr_write_t     wr_req_i,
  input  logic                        commit_i,
  input  logic                        flush_i,
  output csr_addr_pkg::csr_wr_strobe_t wr_strobe_o
);
  import csr_addr_pkg::*;

  csr_write_t pend_q;
  logic       pend_valid_q;
  logic       fire;

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      pend_q <= wr_req_i;
    end
  end

  // a newer request replaces the pending one
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pend_valid_q <= 1'b0;
    end else if (wr_en_i) begin
      pend_valid_q <= 1'b1;
    end else if (flush_i || commit_i) begin
      pend_valid_q <= 1'b0;
    end
  end

  assign fire = commit_i && pend_valid_q;

  always_comb begin
    wr_strobe_o      = '0;
    wr_strobe_o.data = pend_q.data;
    if (fire) begin
      case (pend_q.addr)
        ADDR_MSTATUS:  wr_strobe_o.mstatus  = 1'b1;
        ADDR_MEPC:     wr_strobe_o.mepc     = 1'b1;
        ADDR_MCAUSE:   wr_strobe_o.mcause   = 1'b1;
        ADDR_MCYCLE:   wr_strobe_o.mcycle   = 1'b1;
        ADDR_MINSTRET: wr_strobe_o.minstret = 1'b1;
        default: begin
          // mip, the user counters and unknown addresses match no slot
          for (int s = 0; s < N_SLOTS; s++) begin
            wr_strobe_o.slot[s] = (pend_q.addr == SLOT_ADDR[s]);
          end
        end
      endcase
    end
  end

  // one committed write touches one register at most
  a_one_target: assert property (@(posedge clk) disable iff (reset)
    $onehot0({wr_strobe_o.slot, wr_strobe_o.mstatus, wr_strobe_o.mepc,
              wr_strobe_o.mcause, wr_strobe_o.mcycle, wr_strobe_o.minstret}));

endmodule

// File: logic/csr_state_pkg.sv
//******************************
// privilege levels, mstatus layout and mask,
// trap inputs and machine interrupt lines
//******************************

package csr_state_pkg;

  // only machine and user modes exist
  typedef enum logic [1:0] {
    USER    = 2'b00,
    MACHINE = 2'b11
  } privilege_t;

  // mstatus with the machine fields at their ISA positions
  typedef struct packed {
    logic [csr_addr_pkg::CSR_W-14:0] wpri_hi;
    logic [1:0]                      mpp;
    logic [2:0]                      wpri_10_8;
    logic                            mpie;
    logic [2:0]                      wpri_6_4;
    logic                            mie;
    logic [2:0]                      wpri_2_0;
  } mstatus_t;

  // mie (3), mpie (7) and mpp (12:11)
  localparam csr_addr_pkg::csr_data_t MSTATUS_WR_MASK = 64'h0000_0000_0000_1888;

  typedef struct packed {
    logic                    exception;
    logic                    mret;
    csr_addr_pkg::csr_data_t pc;
    csr_addr_pkg::csr_data_t cause;
  } trap_in_t;

  // level sensitive machine interrupt lines
  typedef struct packed {
    logic m_ext;
    logic m_soft;
    logic m_timer;
  } irq_t;

  // mip and mie bit positions
  localparam int IRQ_M_SOFT  = 3;
  localparam int IRQ_M_TIMER = 7;
  localparam int IRQ_M_EXT   = 11;

endpackage

// File: logic/csr_addr_pkg.sv
//******************************
// CSR data and address widths, address map,
// plain register slots and write request types
//******************************

package csr_addr_pkg;

  localparam int CSR_W        = 64;
  localparam int CSR_ADDR_W   = 12;
  // instructions retired per cycle, 0 to 4
  localparam int COMMIT_CNT_W = 3;

  typedef logic [CSR_W-1:0]      csr_data_t;
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

  // machine mode address map
  localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
  localparam csr_addr_t ADDR_MIE      = 12'h304;
  localparam csr_addr_t ADDR_MTVEC    = 12'h305;
  localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
  localparam csr_addr_t ADDR_MEPC     = 12'h341;
  localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
  localparam csr_addr_t ADDR_MIP      = 12'h344;
  localparam csr_addr_t ADDR_SATP     = 12'h180;
  localparam csr_addr_t ADDR_MCYCLE   = 12'hb00;
  localparam csr_addr_t ADDR_MINSTRET = 12'hb02;
  // user read-only shadows of the machine counters
  localparam csr_addr_t ADDR_CYCLE    = 12'hc00;
  localparam csr_addr_t ADDR_INSTRET  = 12'hc02;

  // bank of plain software-writable registers
  localparam int N_SLOTS       = 4;
  localparam int SLOT_MTVEC    = 0;
  localparam int SLOT_MSCRATCH = 1;
  localparam int SLOT_MIE      = 2;
  localparam int SLOT_SATP     = 3;

  // address of each slot, indexed by the slot numbers above
  localparam csr_addr_t SLOT_ADDR [N_SLOTS] = '{
    ADDR_MTVEC, ADDR_MSCRATCH, ADDR_MIE, ADDR_SATP
  };

  typedef struct packed {
    csr_addr_t addr;
    csr_data_t data;
  } csr_write_t;

  typedef struct packed {
    logic [N_SLOTS-1:0] slot;
    logic               mstatus;
    logic               mepc;
    logic               mcause;
    logic               mcycle;
    logic               minstret;
    csr_data_t          data;
  } csr_wr_strobe_t;

endpackage
